/* common/cnn_consts.svh */
// cnn accelerator constants for array dimensions, data widths and register offsets
`ifndef CNN_CONSTS_SVH
`define CNN_CONSTS_SVH

// image, kernel and output map edge lengths
`define CNN_IMG_DIM 5
`define CNN_KER_DIM 3
`define CNN_OUT_DIM 3

// element counts of the flattened arrays
`define CNN_IMG_N 25
`define CNN_KER_N 9
`define CNN_OUT_N 9

// sample and result widths
`define CNN_PIX_W 8
`define CNN_RES_W 16

// output pixel index, wide enough for 0..8
`define CNN_IDX_W 4

// wishbone data and local offset widths, 4 KB window
`define CNN_BUS_W 32
`define CNN_ADR_W 12

// register map, byte offsets within the window
`define CNN_REG_CTRL   12'h000
`define CNN_REG_IMAGE  12'h004
`define CNN_REG_KERNEL 12'h008
`define CNN_REG_READY  12'h00C
// first of nine result words, one word apart
`define CNN_REG_RESULT 12'h080

`endif

/* common/cnn_pkg.sv */
// cnn data types for samples, taps, products, result maps and controller states
`include "cnn_consts.svh"

package cnn_pkg;

    // one 8-bit image sample
    typedef logic [`CNN_PIX_W-1:0] pixel_t;

    // one kernel tap, same width as a sample
    typedef logic [`CNN_PIX_W-1:0] weight_t;

    // full-width product of sample and tap
    typedef logic [2*`CNN_PIX_W-1:0] product_t;

    // output pixel, wraps modulo 2^16
    typedef logic [`CNN_RES_W-1:0] result_t;

    // flattened row-major arrays
    typedef pixel_t  [`CNN_IMG_N-1:0] image_t;
    typedef weight_t [`CNN_KER_N-1:0] kernel_t;
    typedef result_t [`CNN_OUT_N-1:0] result_map_t;

    // output pixel index, row*3 + col
    typedef logic [`CNN_IDX_W-1:0] out_idx_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ENTER,
        ST_COMPUTE,
        ST_DRAIN,
        ST_DONE
    } conv_state_t;

    // status word, bit 2 down to bit 0
    typedef struct packed {
        logic data_ready;
        logic done;
        logic busy;
    } status_t;

endpackage

/* common/bus_pkg.sv */
// wishbone classic request and response bundles for the accelerator port
`include "cnn_consts.svh"

package bus_pkg;

    // master to slave, held until ack
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`CNN_ADR_W-1:0] adr;
        logic [`CNN_BUS_W-1:0] dat;
    } wb_req_t;

    // slave to master
    // read data is only meaningful with ack
    typedef struct packed {
        logic                  ack;
        logic [`CNN_BUS_W-1:0] dat;
    } wb_rsp_t;

endpackage

/* verilog/sample_buffer.sv */
// auto-incrementing load buffer with a saturating write index
`timescale 1ns/1ps

module sample_buffer #(
    parameter type elem_t = logic [7:0],
    parameter int  DEPTH  = 9
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  logic                clear,
    input  elem_t               din,
    output elem_t [DEPTH-1:0]   contents
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [IDX_W-1:0] wr_idx;
    logic             at_last;

    // index parks here, further pushes overwrite
    assign at_last = (wr_idx == IDX_W'(DEPTH - 1));

    // write index
    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_idx <= '0;
        end else if (clear) begin
            wr_idx <= '0;
        end else if (push && !at_last) begin
            wr_idx <= wr_idx + 1'b1;
        end
    end

    // storage, zero out of reset
    // clear only rewinds the index
    always_ff @(posedge clk) begin
        if (!rst) begin
            contents <= '0;
        end else if (push) begin
            contents[wr_idx] <= din;
        end
    end

    // register block never issues both strobes for one transfer
    a_push_clear: assert property (@(posedge clk) disable iff (!rst) !(push && clear));

endmodule

/* cnn_core/conv_ctrl.sv */
// convolution sequencer, walks the nine output pixels then drains and signals finish
`timescale 1ns/1ps
`include "cnn_consts.svh"

module conv_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              go,
    output logic              issue,
    output cnn_pkg::out_idx_t index,
    output logic              finish
);
    import cnn_pkg::*;

    localparam out_idx_t LAST_IDX = out_idx_t'(`CNN_OUT_N - 1);

    conv_state_t state;
    conv_state_t state_nxt;
    out_idx_t    index_nxt;

    always_comb begin
        state_nxt = state;
        index_nxt = index;
        case (state)
            ST_IDLE: begin
                if (go) begin
                    state_nxt = ST_ENTER;
                end
            end
            ST_ENTER: begin
                // go drops if software re-arms mid-load
                if (go) begin
                    state_nxt = ST_COMPUTE;
                    index_nxt = '0;
                end else begin
                    state_nxt = ST_IDLE;
                end
            end
            ST_COMPUTE: begin
                if (index == LAST_IDX) begin
                    state_nxt = ST_DRAIN;
                    index_nxt = '0;
                end else begin
                    index_nxt = index + 1'b1;
                end
            end
            // last sum still in flight in the mac
            ST_DRAIN: state_nxt = ST_DONE;
            ST_DONE:  state_nxt = ST_IDLE;
            default:  state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= ST_IDLE;
            index <= '0;
        end else begin
            state <= state_nxt;
            index <= index_nxt;
        end
    end

    // both decoded from state flops, glitch free
    assign issue  = (state == ST_COMPUTE);
    assign finish = (state == ST_DONE);

    // mac result map has only nine slots
    a_index_range: assert property (@(posedge clk) disable iff (!rst)
        issue |-> (index < `CNN_OUT_N));

endmodule

/* cnn_core/conv_mac.sv */
// conv datapath, 3x3 window select, nine registered products, then a wrapped sum
`timescale 1ns/1ps
`include "cnn_consts.svh"

module conv_mac (
    input  logic                 clk,
    input  logic                 rst,
    input  cnn_pkg::image_t      image,
    input  cnn_pkg::kernel_t     kernel,
    input  logic                 issue,
    input  cnn_pkg::out_idx_t    index,
    output cnn_pkg::result_map_t results
);
    import cnn_pkg::*;

    localparam int BASE_W = $clog2(`CNN_IMG_N);

    logic [BASE_W-1:0] base;
    product_t          prod_d [`CNN_KER_N];
    product_t          prod_q [`CNN_KER_N];
    out_idx_t          idx_q;
    logic              valid_q;
    result_t           sum;

    // top-left sample of the window
    // row index/3, column index%3
    assign base = BASE_W'((index / `CNN_OUT_DIM) * `CNN_IMG_DIM + (index % `CNN_OUT_DIM));

    // nine parallel products
    // tap t sits at kernel row t/3, column t%3
    always_comb begin
        for (int t = 0; t < `CNN_KER_N; t++) begin
            prod_d[t] = product_t'(image[base + (t / `CNN_KER_DIM) * `CNN_IMG_DIM
                                         + (t % `CNN_KER_DIM)])
                        * product_t'(kernel[t]);
        end
    end

    // stage 1
    // products plus the slot they belong to
    always_ff @(posedge clk) begin
        if (issue) begin
            for (int t = 0; t < `CNN_KER_N; t++) begin
                prod_q[t] <= prod_d[t];
            end
            idx_q <= index;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue;
        end
    end

    // adder tree, carries past bit 15 drop out
    always_comb begin
        sum = '0;
        for (int t = 0; t < `CNN_KER_N; t++) begin
            sum = sum + prod_q[t];
        end
    end

    // stage 2
    // store into the output map
    always_ff @(posedge clk) begin
        if (!rst) begin
            results <= '0;
        end else if (valid_q) begin
            results[idx_q] <= sum;
        end
    end

endmodule

/* verilog/cnn_regs.sv */
// wishbone slave for the cnn accelerator, load strobes, control flags and readback
`timescale 1ns/1ps
`include "cnn_consts.svh"

module cnn_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  bus_pkg::wb_req_t     wb_req,
    output bus_pkg::wb_rsp_t     wb_rsp,
    output logic                 image_push,
    output logic                 kernel_push,
    output cnn_pkg::pixel_t      sample,
    output logic                 load_clear,
    output logic                 go,
    input  logic                 finish,
    input  cnn_pkg::result_map_t results
);
    import cnn_pkg::*;

    status_t                 status;
    logic                    ack;
    logic [`CNN_BUS_W-1:0]   rdat;
    logic [`CNN_BUS_W-1:0]   rd_word;
    logic                    acc;
    logic                    wr;
    logic                    ready_wr;
    logic [`CNN_ADR_W-1:0]   res_off;
    logic                    res_hit;
    out_idx_t                res_sel;

    // new transfer, ignored while the previous ack is out
    assign acc = wb_req.cyc && wb_req.stb && !ack;
    assign wr  = acc && wb_req.we;

    // write strobes, all land on the edge that raises ack
    assign image_push  = wr && (wb_req.adr == `CNN_REG_IMAGE);
    assign kernel_push = wr && (wb_req.adr == `CNN_REG_KERNEL);
    assign load_clear  = wr && (wb_req.adr == `CNN_REG_CTRL);
    assign ready_wr    = wr && (wb_req.adr == `CNN_REG_READY);

    // low byte carries the sample or tap
    assign sample = wb_req.dat[`CNN_PIX_W-1:0];

    // engine runs once armed and loaded
    assign go = status.busy && status.data_ready;

    // result window decode
    assign res_off = wb_req.adr - `CNN_REG_RESULT;
    assign res_sel = res_off[`CNN_IDX_W+1:2];
    assign res_hit = (wb_req.adr >= `CNN_REG_RESULT)
                     && (res_off[1:0] == 2'b00)
                     && (res_off[`CNN_ADR_W-1:2] < `CNN_OUT_N);

    // read mux, unmapped reads give zero
    always_comb begin
        rd_word = '0;
        if (wb_req.adr == `CNN_REG_CTRL) begin
            rd_word = `CNN_BUS_W'(status);
        end else if (res_hit) begin
            rd_word = `CNN_BUS_W'(results[res_sel]);
        end
    end

    // status flags
    // a CTRL write in the finish cycle re-arms
    always_ff @(posedge clk) begin
        if (!rst) begin
            status <= '0;
        end else begin
            if (finish) begin
                status.busy <= 1'b0;
                status.done <= 1'b1;
            end
            if (load_clear) begin
                status.busy       <= 1'b1;
                status.done       <= 1'b0;
                status.data_ready <= 1'b0;
            end
            if (ready_wr) begin
                status.data_ready <= 1'b1;
            end
        end
    end

    // single-cycle ack, one cycle after strobe
    always_ff @(posedge clk) begin
        if (!rst) begin
            ack <= 1'b0;
        end else begin
            ack <= acc;
        end
    end

    // read data captured alongside ack
    always_ff @(posedge clk) begin
        if (acc) begin
            rdat <= wb_req.we ? '0 : rd_word;
        end
    end

    assign wb_rsp.ack = ack;
    assign wb_rsp.dat = rdat;

    // every access is a single transfer, no back-to-back ack
    a_ack_single: assert property (@(posedge clk) disable iff (!rst) ack |=> !ack);

    // engine only reports completion of an armed run
    a_finish_busy: assert property (@(posedge clk) disable iff (!rst) finish |-> status.busy);

endmodule

/* verilog/cnn_accel.sv */
// cnn accelerator top, wishbone register block feeding load buffers and the conv engine
`timescale 1ns/1ps
`include "cnn_consts.svh"

module cnn_accel (
    input  logic             clk,
    input  logic             rst,
    input  bus_pkg::wb_req_t wb_req,
    output bus_pkg::wb_rsp_t wb_rsp,
    output logic             done
);
    import cnn_pkg::*;

    // load path
    logic        image_push;
    logic        kernel_push;
    logic        load_clear;
    pixel_t      sample;
    image_t      image;
    kernel_t     kernel;

    // control and compute path
    logic        go;
    logic        issue;
    logic        finish;
    out_idx_t    index;
    result_map_t results;

    cnn_regs i_cnn_regs (
        .clk         (clk),
        .rst         (rst),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .image_push  (image_push),
        .kernel_push (kernel_push),
        .sample      (sample),
        .load_clear  (load_clear),
        .go          (go),
        .finish      (finish),
        .results     (results)
    );

    // 5x5 image store
    sample_buffer #(
        .elem_t (pixel_t),
        .DEPTH  (`CNN_IMG_N)
    ) i_image_buf (
        .clk      (clk),
        .rst      (rst),
        .push     (image_push),
        .clear    (load_clear),
        .din      (sample),
        .contents (image)
    );

    // 3x3 kernel store
    // taps share the sample lane, same width
    sample_buffer #(
        .elem_t (weight_t),
        .DEPTH  (`CNN_KER_N)
    ) i_kernel_buf (
        .clk      (clk),
        .rst      (rst),
        .push     (kernel_push),
        .clear    (load_clear),
        .din      (sample),
        .contents (kernel)
    );

    conv_ctrl i_conv_ctrl (
        .clk    (clk),
        .rst    (rst),
        .go     (go),
        .issue  (issue),
        .index  (index),
        .finish (finish)
    );

    conv_mac i_conv_mac (
        .clk     (clk),
        .rst     (rst),
        .image   (image),
        .kernel  (kernel),
        .issue   (issue),
        .index   (index),
        .results (results)
    );

    // one pulse per completed run
    assign done = finish;

endmodule

/* tests/cnn_cases.svh */
// cnn accelerator stimulus table, images, kernels and expected result maps
`ifndef CNN_CASES_SVH
`define CNN_CASES_SVH

// one row per case, row-major samples and taps
// expected map is the windowed sum of image times kernel, modulo 2^16
localparam int N_FIXED = 4;
// last case is filled at run time from the lcg
localparam int N_CASES = N_FIXED + 1;

pixel_t case_img [N_FIXED][`CNN_IMG_N] = '{
    // ramp 1..25
    '{8'd1,  8'd2,  8'd3,  8'd4,  8'd5,
      8'd6,  8'd7,  8'd8,  8'd9,  8'd10,
      8'd11, 8'd12, 8'd13, 8'd14, 8'd15,
      8'd16, 8'd17, 8'd18, 8'd19, 8'd20,
      8'd21, 8'd22, 8'd23, 8'd24, 8'd25},
    // steps of ten
    '{8'd0,   8'd10,  8'd20,  8'd30,  8'd40,
      8'd50,  8'd60,  8'd70,  8'd80,  8'd90,
      8'd100, 8'd110, 8'd120, 8'd130, 8'd140,
      8'd150, 8'd160, 8'd170, 8'd180, 8'd190,
      8'd200, 8'd210, 8'd220, 8'd230, 8'd240},
    // full scale, sum wraps
    '{default: 8'hff},
    // ramp again, for the saturation run
    '{8'd1,  8'd2,  8'd3,  8'd4,  8'd5,
      8'd6,  8'd7,  8'd8,  8'd9,  8'd10,
      8'd11, 8'd12, 8'd13, 8'd14, 8'd15,
      8'd16, 8'd17, 8'd18, 8'd19, 8'd20,
      8'd21, 8'd22, 8'd23, 8'd24, 8'd25}
};

weight_t case_ker [N_FIXED][`CNN_KER_N] = '{
    '{default: 8'd1},
    // identity centre
    '{8'd0, 8'd0, 8'd0, 8'd0, 8'd1, 8'd0, 8'd0, 8'd0, 8'd0},
    '{default: 8'hff},
    '{default: 8'd1}
};

// tenth tap pushed after the nine, lands on tap 8
logic    case_extra_en [N_FIXED] = '{1'b0, 1'b0, 1'b0, 1'b1};
weight_t case_extra    [N_FIXED] = '{8'd0, 8'd0, 8'd0, 8'd5};

result_t case_exp [N_FIXED][`CNN_OUT_N] = '{
    '{16'd63,  16'd72,  16'd81,  16'd108, 16'd117, 16'd126, 16'd153, 16'd162, 16'd171},
    '{16'd60,  16'd70,  16'd80,  16'd110, 16'd120, 16'd130, 16'd160, 16'd170, 16'd180},
    // 9 * 255 * 255 = 585225, minus 8 * 65536
    '{default: 16'hee09},
    // tap 8 now 5, adds 4x the bottom-right sample
    '{16'd115, 16'd128, 16'd141, 16'd180, 16'd193, 16'd206, 16'd245, 16'd258, 16'd271}
};

`endif

/* tests/tb_cnn_accel.sv */
// testbench for the cnn accelerator driving table cases over the wishbone port
`timescale 1ns/1ps
`include "cnn_consts.svh"

module tb_cnn_accel;
    import cnn_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int RST_CYCLES  = 10;
    localparam int CASE_CYCLES = 200;

    // expected status words in data_ready done busy order
    localparam status_t STAT_RESET   = '0;
    localparam status_t STAT_ARMED   = '{data_ready: 1'b0, done: 1'b0, busy: 1'b1};
    localparam status_t STAT_RUNNING = '{data_ready: 1'b1, done: 1'b0, busy: 1'b1};
    localparam status_t STAT_DONE    = '{data_ready: 1'b1, done: 1'b1, busy: 1'b0};

    logic             clk;
    logic             rst;
    bus_pkg::wb_req_t wb_req;
    bus_pkg::wb_rsp_t wb_rsp;
    logic             done;

    int               errors;
    int               done_count;
    logic [31:0]      lcg_state;

    // case under test
    pixel_t  cur_img [`CNN_IMG_N];
    weight_t cur_ker [`CNN_KER_N];
    result_t cur_exp [`CNN_OUT_N];
    logic    cur_extra_en;
    weight_t cur_extra;

    `include "cnn_cases.svh"

    cnn_accel i_cnn_accel (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .done   (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // count done pulses at mid-cycle
    always @(negedge clk) begin
        if (rst && done) begin
            done_count++;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_result(input result_t got, input result_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_status(input status_t got, input status_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got ready/done/busy %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input logic [`CNN_BUS_W-1:0] got,
                              input logic [`CNN_BUS_W-1:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // ack is registered so look just past each edge
    task automatic wait_ack();
        do begin
            @(posedge clk);
            #1;
        end while (!wb_rsp.ack);
    endtask

    task automatic wb_write(input logic [`CNN_ADR_W-1:0] adr, input logic [`CNN_BUS_W-1:0] dat);
        @(posedge clk);
        #1;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
        wait_ack();
        wb_req = '0;
    endtask

    task automatic wb_read(input logic [`CNN_ADR_W-1:0] adr, output logic [`CNN_BUS_W-1:0] dat);
        @(posedge clk);
        #1;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0};
        wait_ack();
        dat = wb_rsp.dat;
        wb_req = '0;
    endtask

    task automatic read_status(output status_t st);
        logic [`CNN_BUS_W-1:0] w;
        wb_read(`CNN_REG_CTRL, w);
        check_word({w[`CNN_BUS_W-1:3], 3'b000}, '0, "status upper bits");
        st = status_t'(w[2:0]);
    endtask

    // all nine result words against cur_exp
    task automatic check_all_results(input string what);
        logic [`CNN_BUS_W-1:0] w;
        for (int i = 0; i < `CNN_OUT_N; i++) begin
            wb_read(`CNN_REG_RESULT + `CNN_ADR_W'(4 * i), w);
            check_result(w[`CNN_RES_W-1:0], cur_exp[i], $sformatf("%s result %0d", what, i));
            check_word(w >> `CNN_RES_W, '0, $sformatf("%s result %0d upper bits", what, i));
        end
    endtask

    // random image and kernel with the expected map from the windowed sum rule
    task automatic fill_random_case();
        int sum;
        int r;
        int c;
        for (int i = 0; i < `CNN_IMG_N; i++) begin
            lcg_state = lcg_next(lcg_state);
            cur_img[i] = lcg_state[23:16];
        end
        for (int t = 0; t < `CNN_KER_N; t++) begin
            lcg_state = lcg_next(lcg_state);
            cur_ker[t] = lcg_state[23:16];
        end
        cur_extra_en = 1'b0;
        cur_extra = '0;
        for (int o = 0; o < `CNN_OUT_N; o++) begin
            r = o / `CNN_OUT_DIM;
            c = o % `CNN_OUT_DIM;
            sum = 0;
            for (int t = 0; t < `CNN_KER_N; t++) begin
                sum += int'(cur_img[(r + t / `CNN_KER_DIM) * `CNN_IMG_DIM + c + t % `CNN_KER_DIM])
                       * int'(cur_ker[t]);
            end
            cur_exp[o] = result_t'(sum);
        end
    endtask

    task automatic run_case(input int k);
        status_t st;
        int      done_before;
        if (k < N_FIXED) begin
            cur_img = case_img[k];
            cur_ker = case_ker[k];
            cur_exp = case_exp[k];
            cur_extra_en = case_extra_en[k];
            cur_extra = case_extra[k];
        end else begin
            fill_random_case();
        end
        done_before = done_count;
        // arming clears both load indexes
        wb_write(`CNN_REG_CTRL, '0);
        read_status(st);
        check_status(st, STAT_ARMED, $sformatf("case %0d after arm", k));
        for (int i = 0; i < `CNN_IMG_N; i++) begin
            wb_write(`CNN_REG_IMAGE, `CNN_BUS_W'(cur_img[i]));
        end
        for (int t = 0; t < `CNN_KER_N; t++) begin
            wb_write(`CNN_REG_KERNEL, `CNN_BUS_W'(cur_ker[t]));
        end
        if (cur_extra_en) begin
            wb_write(`CNN_REG_KERNEL, `CNN_BUS_W'(cur_extra));
        end
        wb_write(`CNN_REG_READY, 32'h1);
        read_status(st);
        check_status(st, STAT_RUNNING, $sformatf("case %0d after ready", k));
        // poll until the sticky done flag sets
        do begin
            read_status(st);
        end while (!st.done);
        check_status(st, STAT_DONE, $sformatf("case %0d at completion", k));
        if (done_count != done_before + 1) begin
            errors++;
            $display("ERR %0t: case %0d saw %0d done pulses, expected one",
                     $time, k, done_count - done_before);
        end
        check_all_results($sformatf("case %0d", k));
    endtask

    initial begin
        logic [`CNN_BUS_W-1:0] w;
        status_t               st;
        clk = 1'b0;
        rst = 1'b0;
        wb_req = '0;
        errors = 0;
        done_count = 0;
        lcg_state = 32'h4df9bf7f;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b1;

        // everything zero out of reset
        read_status(st);
        check_status(st, STAT_RESET, "status after reset");
        cur_exp = '{default: '0};
        check_all_results("after reset");

        for (int k = 0; k < N_CASES; k++) begin
            run_case(k);
        end

        // unmapped offsets in the register hole, past the result window and misaligned
        wb_read(12'h010, w);
        check_word(w, '0, "read of offset 010");
        wb_read(`CNN_REG_RESULT + 12'h024, w);
        check_word(w, '0, "read past result window");
        wb_read(`CNN_REG_RESULT + 12'h002, w);
        check_word(w, '0, "misaligned result read");
        wb_write(12'h010, 32'hdead_beef);
        wb_write(`CNN_REG_RESULT + 12'h024, 32'h1234_5678);
        wb_write(12'hffc, 32'hffff_ffff);
        read_status(st);
        check_status(st, STAT_DONE, "status after unmapped writes");
        // last case map must still stand
        check_all_results("after unmapped writes");

        // one pulse per run and none between runs
        if (done_count != N_CASES) begin
            errors++;
            $display("ERR %0t: %0d done pulses over %0d runs", $time, done_count, N_CASES);
        end

        $display("summary: %0d errors, %0d done pulses", errors, done_count);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog sized by case count
    initial begin
        #(N_CASES * CASE_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", N_CASES * CASE_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+common
+incdir+tests
common/cnn_pkg.sv
common/bus_pkg.sv
verilog/sample_buffer.sv
cnn_core/conv_ctrl.sv
cnn_core/conv_mac.sv
verilog/cnn_regs.sv
verilog/cnn_accel.sv
tests/tb_cnn_accel.sv

/* Makefile */
TOP := tb_cnn_accel

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_cnn
	./obj_dir/sim_cnn | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
